// ==== src/shell_consts.svh ====
`ifndef SHELL_CONSTS_SVH
`define SHELL_CONSTS_SVH

// --------------------
// Bus widths
// --------------------
`define SHELL_CTRL_ADDR_W 8
`define SHELL_CTRL_DATA_W 32
`define SHELL_MEM_ADDR_W 32
`define SHELL_MEM_DATA_W 32
`define SHELL_STATUS_W 16

// --------------------
// Control register map, byte addresses
// --------------------
`define SHELL_ADDR_ID0 8'h00
`define SHELL_ADDR_ID1 8'h04
`define SHELL_ADDR_STATUS0 8'h08
`define SHELL_ADDR_STATUS1 8'h0C
`define SHELL_ADDR_VDIP 8'h10
`define SHELL_ADDR_VLED 8'h14
`define SHELL_ADDR_SCRATCH 8'h18

// Identification words
`define SHELL_ID0 32'h0001_F00D
`define SHELL_ID1 32'h0002_CAFE

// LED value once out of reset
`define SHELL_VLED_PATTERN 16'hBEEF

`endif

// ==== src/shell_pkg.sv ====
`default_nettype none

`include "shell_consts.svh"

package shell_pkg;

  // --------------------
  // Control bus
  // --------------------
  typedef logic [`SHELL_CTRL_DATA_W-1:0] ctrl_data_t;
  typedef logic [`SHELL_CTRL_ADDR_W-1:0] ctrl_addr_t;
  typedef logic [`SHELL_CTRL_DATA_W/8-1:0] ctrl_sel_t;

  typedef struct packed {
    ctrl_addr_t addr;
    ctrl_data_t dat;
    ctrl_sel_t  sel;
    logic       we;
  } ctrl_req_t;

  // --------------------
  // Memory bus
  // --------------------
  typedef logic [`SHELL_MEM_DATA_W-1:0] mem_data_t;
  typedef logic [`SHELL_MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`SHELL_MEM_DATA_W/8-1:0] mem_sel_t;

  typedef struct packed {
    mem_addr_t addr;
    mem_data_t dat;
    mem_sel_t  sel;
    logic      we;
  } mem_req_t;

  // DIP switches and LEDs
  typedef logic [`SHELL_STATUS_W-1:0] status_word_t;

endpackage

`default_nettype wire

// ==== src/status_leds.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_consts.svh"

module status_leds import shell_pkg::*; (
  input  wire logic         clk_main_a0,
  input  wire logic         rst_main_n_sync,
  input  wire status_word_t vdip_i,
  output status_word_t      vdip_sync_o,
  output status_word_t      vled_o
);

  status_word_t vdip_q;
  status_word_t vled_q;

  // --------------------
  // DIP switch synchronizer
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q      <= '0;
      vdip_sync_o <= '0;
    end else begin
      vdip_q      <= vdip_i;
      vdip_sync_o <= vdip_q;
    end
  end

  // --------------------
  // Virtual LEDs
  // --------------------
  // Pattern register, then output flop
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
      vled_o <= '0;
    end else begin
      vled_q <= `SHELL_VLED_PATTERN;
      vled_o <= vled_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/wb_reg_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_reg_slice #(
  parameter type req_t  = logic,
  parameter type data_t = logic
) (
  input  wire logic clk_main_a0,
  input  wire logic rst_main_n_sync,

  // Upstream, slave side
  input  wire logic s_cyc_i,
  input  wire logic s_stb_i,
  input  wire req_t s_req_i,
  output logic      s_ack_o,
  output data_t     s_dat_o,

  // Downstream, master side
  output logic      m_cyc_o,
  output logic      m_stb_o,
  output req_t      m_req_o,
  input  wire logic m_ack_i,
  input  wire data_t m_dat_i
);

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ISSUED = 2'd1,
    ST_ACKING = 2'd2
  } slice_state_t;

  slice_state_t state_q;

  // --------------------
  // Controller
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (s_cyc_i && s_stb_i) begin
            state_q <= ST_ISSUED;
          end
        end
        ST_ISSUED: begin
          if (m_ack_i) begin
            state_q <= ST_ACKING;
          end
        end
        // Upstream stb still high here belongs to the finished cycle
        ST_ACKING: state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and read data holding registers
  always_ff @(posedge clk_main_a0) begin
    if (state_q == ST_IDLE && s_cyc_i && s_stb_i) begin
      m_req_o <= s_req_i;
    end
    if (state_q == ST_ISSUED && m_ack_i) begin
      s_dat_o <= m_dat_i;
    end
  end

  assign m_cyc_o = (state_q == ST_ISSUED);
  assign m_stb_o = (state_q == ST_ISSUED);
  assign s_ack_o = (state_q == ST_ACKING);

endmodule

`default_nettype wire

// ==== src/ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_consts.svh"

module ctrl_regs import shell_pkg::*; (
  input  wire logic         clk_main_a0,
  input  wire logic         rst_main_n_sync,
  input  wire logic         cyc_i,
  input  wire logic         stb_i,
  input  wire ctrl_req_t    req_i,
  output logic              ack_o,
  output ctrl_data_t        dat_o,
  input  wire status_word_t vdip_i,
  input  wire status_word_t vled_i
);

  ctrl_data_t scratch_q;
  ctrl_data_t rd_data;
  logic       access;

  // New access only, the held stb during ack is the same cycle
  assign access = cyc_i && stb_i && !ack_o;

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    case (req_i.addr)
      `SHELL_ADDR_ID0:     rd_data = `SHELL_ID0;
      `SHELL_ADDR_ID1:     rd_data = `SHELL_ID1;
      `SHELL_ADDR_STATUS0: rd_data = '0;
      `SHELL_ADDR_STATUS1: rd_data = '0;
      `SHELL_ADDR_VDIP:    rd_data = ctrl_data_t'(vdip_i);
      `SHELL_ADDR_VLED:    rd_data = ctrl_data_t'(vled_i);
      `SHELL_ADDR_SCRATCH: rd_data = scratch_q;
      default:             rd_data = '0;
    endcase
  end

  // --------------------
  // Ack and scratch register
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ack_o     <= 1'b0;
      scratch_q <= '0;
    end else begin
      ack_o <= access;
      // Byte-masked write, other addresses are read only
      if (access && req_i.we && req_i.addr == `SHELL_ADDR_SCRATCH) begin
        for (int b = 0; b < $bits(ctrl_sel_t); b++) begin
          if (req_i.sel[b]) begin
            scratch_q[b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge clk_main_a0) begin
    if (access) begin
      dat_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import shell_pkg::*; (
  input  wire logic      clk_main_a0,
  input  wire logic      rst_main_n_sync,

  // DMA master
  input  wire logic      dma_cyc_i,
  input  wire logic      dma_stb_i,
  input  wire mem_req_t  dma_req_i,
  output logic           dma_ack_o,
  output mem_data_t      dma_dat_o,

  // Compute core master
  input  wire logic      core_cyc_i,
  input  wire logic      core_stb_i,
  input  wire mem_req_t  core_req_i,
  output logic           core_ack_o,
  output mem_data_t      core_dat_o,

  // Shared downstream port
  output logic           m_cyc_o,
  output logic           m_stb_o,
  output mem_req_t       m_req_o,
  input  wire logic      m_ack_i,
  input  wire mem_data_t m_dat_i
);

  logic dma_req;
  logic core_req;
  logic pick_core;
  logic gnt_valid_q;
  // Current owner while granted, last winner while idle
  logic owner_core_q;

  assign dma_req  = dma_cyc_i && dma_stb_i;
  assign core_req = core_cyc_i && core_stb_i;

  // On a tie the loser of the previous round goes first
  assign pick_core = core_req && (!dma_req || !owner_core_q);

  // --------------------
  // Grant register
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      gnt_valid_q  <= 1'b0;
      owner_core_q <= 1'b1;
    end else if (gnt_valid_q) begin
      if (m_ack_i) begin
        gnt_valid_q <= 1'b0;
      end
    end else if (dma_req || core_req) begin
      gnt_valid_q  <= 1'b1;
      owner_core_q <= pick_core;
    end
  end

  // --------------------
  // Request path
  // --------------------
  assign m_cyc_o = gnt_valid_q && (owner_core_q ? core_cyc_i : dma_cyc_i);
  assign m_stb_o = gnt_valid_q && (owner_core_q ? core_stb_i : dma_stb_i);
  assign m_req_o = owner_core_q ? core_req_i : dma_req_i;

  // Response only to the owner
  assign dma_ack_o  = gnt_valid_q && !owner_core_q && m_ack_i;
  assign core_ack_o = gnt_valid_q && owner_core_q && m_ack_i;
  assign dma_dat_o  = (gnt_valid_q && !owner_core_q) ? m_dat_i : '0;
  assign core_dat_o = (gnt_valid_q && owner_core_q) ? m_dat_i : '0;

endmodule

`default_nettype wire

// ==== src/shell_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module shell_top import shell_pkg::*; (
  input  wire logic         clk_main_a0,
  input  wire logic         rst_main_n_sync,

  // Control bus
  input  wire logic         ctrl_cyc_i,
  input  wire logic         ctrl_stb_i,
  input  wire ctrl_req_t    ctrl_req_i,
  output logic              ctrl_ack_o,
  output ctrl_data_t        ctrl_dat_o,

  // DMA master
  input  wire logic         dma_cyc_i,
  input  wire logic         dma_stb_i,
  input  wire mem_req_t     dma_req_i,
  output logic              dma_ack_o,
  output mem_data_t         dma_dat_o,

  // Compute core master
  input  wire logic         core_cyc_i,
  input  wire logic         core_stb_i,
  input  wire mem_req_t     core_req_i,
  output logic              core_ack_o,
  output mem_data_t         core_dat_o,

  // External memory
  output logic              mem_cyc_o,
  output logic              mem_stb_o,
  output mem_req_t          mem_req_o,
  input  wire logic         mem_ack_i,
  input  wire mem_data_t    mem_dat_i,

  // Status
  input  wire status_word_t vdip_i,
  output status_word_t      vled_o
);

  status_word_t vdip_sync;
  status_word_t vled;

  logic       regs_cyc;
  logic       regs_stb;
  ctrl_req_t  regs_req;
  logic       regs_ack;
  ctrl_data_t regs_dat;

  logic       arb_cyc;
  logic       arb_stb;
  mem_req_t   arb_req;
  logic       arb_ack;
  mem_data_t  arb_dat;

  // --------------------
  // Status path
  // --------------------
  status_leds u_status_leds (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vdip_i          (vdip_i),
    .vdip_sync_o     (vdip_sync),
    .vled_o          (vled)
  );

  assign vled_o = vled;

  // --------------------
  // Control path
  // --------------------
  wb_reg_slice #(
    .req_t  (ctrl_req_t),
    .data_t (ctrl_data_t)
  ) ctrl_slice (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .s_cyc_i         (ctrl_cyc_i),
    .s_stb_i         (ctrl_stb_i),
    .s_req_i         (ctrl_req_i),
    .s_ack_o         (ctrl_ack_o),
    .s_dat_o         (ctrl_dat_o),
    .m_cyc_o         (regs_cyc),
    .m_stb_o         (regs_stb),
    .m_req_o         (regs_req),
    .m_ack_i         (regs_ack),
    .m_dat_i         (regs_dat)
  );

  ctrl_regs u_ctrl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cyc_i           (regs_cyc),
    .stb_i           (regs_stb),
    .req_i           (regs_req),
    .ack_o           (regs_ack),
    .dat_o           (regs_dat),
    .vdip_i          (vdip_sync),
    .vled_i          (vled)
  );

  // --------------------
  // Memory path
  // --------------------
  mem_arbiter u_mem_arbiter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .dma_cyc_i       (dma_cyc_i),
    .dma_stb_i       (dma_stb_i),
    .dma_req_i       (dma_req_i),
    .dma_ack_o       (dma_ack_o),
    .dma_dat_o       (dma_dat_o),
    .core_cyc_i      (core_cyc_i),
    .core_stb_i      (core_stb_i),
    .core_req_i      (core_req_i),
    .core_ack_o      (core_ack_o),
    .core_dat_o      (core_dat_o),
    .m_cyc_o         (arb_cyc),
    .m_stb_o         (arb_stb),
    .m_req_o         (arb_req),
    .m_ack_i         (arb_ack),
    .m_dat_i         (arb_dat)
  );

  wb_reg_slice #(
    .req_t  (mem_req_t),
    .data_t (mem_data_t)
  ) mem_slice (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .s_cyc_i         (arb_cyc),
    .s_stb_i         (arb_stb),
    .s_req_i         (arb_req),
    .s_ack_o         (arb_ack),
    .s_dat_o         (arb_dat),
    .m_cyc_o         (mem_cyc_o),
    .m_stb_o         (mem_stb_o),
    .m_req_o         (mem_req_o),
    .m_ack_i         (mem_ack_i),
    .m_dat_i         (mem_dat_i)
  );

endmodule

`default_nettype wire

// ==== bench/shell_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_consts.svh"

module shell_properties import shell_pkg::*; (
  input wire logic         clk_main_a0,
  input wire logic         rst_main_n_sync,
  input wire logic         ctrl_cyc_i,
  input wire logic         ctrl_ack_o,
  input wire logic         dma_ack_o,
  input wire logic         core_ack_o,
  input wire logic         mem_stb_o,
  input wire status_word_t vled_o
);

  // Control ack only inside an open bus cycle
  ctrl_ack_in_cycle: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(ctrl_ack_o) |-> ctrl_cyc_i)
    else $error("ctrl_ack_o rose without ctrl_cyc_i");

  // Arbiter answers one master at a time
  single_mem_ack: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(dma_ack_o && core_ack_o))
    else $error("dma_ack_o and core_ack_o high together");

  // Second reset cycle onward the memory strobe is quiet
  mem_stb_reset: assert property (@(posedge clk_main_a0)
    !rst_main_n_sync ##1 !rst_main_n_sync |-> !mem_stb_o)
    else $error("mem_stb_o high during reset");

  vled_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (vled_o == `SHELL_VLED_PATTERN) |=> (vled_o == `SHELL_VLED_PATTERN))
    else $error("vled_o left its pattern");

endmodule

bind shell_top shell_properties u_shell_properties (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .ctrl_cyc_i      (ctrl_cyc_i),
  .ctrl_ack_o      (ctrl_ack_o),
  .dma_ack_o       (dma_ack_o),
  .core_ack_o      (core_ack_o),
  .mem_stb_o       (mem_stb_o),
  .vled_o          (vled_o)
);

`default_nettype wire

// ==== bench/tb_shell_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_consts.svh"

module tb_shell_top import shell_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int ACK_LIMIT      = 40;

  logic         clk_main_a0;
  logic         rst_main_n_sync;
  logic         ctrl_cyc_i;
  logic         ctrl_stb_i;
  ctrl_req_t    ctrl_req_i;
  logic         ctrl_ack_o;
  ctrl_data_t   ctrl_dat_o;
  logic         dma_cyc_i;
  logic         dma_stb_i;
  mem_req_t     dma_req_i;
  logic         dma_ack_o;
  mem_data_t    dma_dat_o;
  logic         core_cyc_i;
  logic         core_stb_i;
  mem_req_t     core_req_i;
  logic         core_ack_o;
  mem_data_t    core_dat_o;
  logic         mem_cyc_o;
  logic         mem_stb_o;
  mem_req_t     mem_req_o;
  logic         mem_ack_i;
  mem_data_t    mem_dat_i;
  status_word_t vdip_i;
  status_word_t vled_o;

  int          err_count;
  int          cycle_count;
  int unsigned rnd_init;

  // Memory model state
  mem_data_t mem_store [mem_addr_t];
  mem_req_t  req_log [$];
  logic      mem_busy;
  int        wait_left;

  shell_top UUT (.*);

  always #10 clk_main_a0 = ~clk_main_a0;

  always @(posedge clk_main_a0) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------
  // Memory model
  // --------------------
  function automatic mem_data_t fill_word(mem_addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  // Wait states are drawn in this process, so the seed goes here
  initial begin
    mem_data_t w;
    rnd_init = $urandom(38);
    forever begin
      @(posedge clk_main_a0);
      mem_ack_i <= 1'b0;
      // The slice still shows the old strobe in the ack cycle
      if (!mem_ack_i && mem_cyc_o && mem_stb_o) begin
        if (!mem_busy) begin
          mem_busy  = 1'b1;
          wait_left = $urandom % 4;
          req_log.push_back(mem_req_o);
        end
        if (wait_left == 0) begin
          w = mem_store.exists(mem_req_o.addr) ? mem_store[mem_req_o.addr]
                                               : fill_word(mem_req_o.addr);
          if (mem_req_o.we) begin
            for (int b = 0; b < 4; b++) begin
              if (mem_req_o.sel[b]) w[b*8 +: 8] = mem_req_o.dat[b*8 +: 8];
            end
            mem_store[mem_req_o.addr] = w;
          end
          mem_dat_i <= w;
          mem_ack_i <= 1'b1;
          mem_busy  = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %b got %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_ctrl_data(input string name, input ctrl_data_t exp, input ctrl_data_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_mem_data(input string name, input mem_data_t exp, input mem_data_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_status(input string name, input status_word_t exp,
                              input status_word_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  // --------------------
  // Bus drivers
  // --------------------
  task automatic ctrl_access(input ctrl_addr_t addr, input ctrl_data_t dat,
                             input ctrl_sel_t sel, input logic we,
                             output ctrl_data_t rdata);
    ctrl_req_t req;
    int        n;
    req.addr = addr;
    req.dat  = dat;
    req.sel  = sel;
    req.we   = we;
    rdata    = '0;
    n        = 0;
    @(posedge clk_main_a0);
    ctrl_cyc_i <= 1'b1;
    ctrl_stb_i <= 1'b1;
    ctrl_req_i <= req;
    // Edge where the slice first samples the strobe
    @(posedge clk_main_a0);
    do begin
      @(posedge clk_main_a0);
      n++;
    end while (!ctrl_ack_o && n < ACK_LIMIT);
    if (!ctrl_ack_o) begin
      $display("Control bus gave no ack for address %h", addr);
      err_count++;
    end else begin
      if (n != 3) begin
        $display("ERROR %0t ctrl_ack_o latency expected 3 got %0d", $time, n);
        err_count++;
      end
      rdata = ctrl_dat_o;
    end
    ctrl_cyc_i <= 1'b0;
    ctrl_stb_i <= 1'b0;
  endtask

  function automatic mem_req_t make_mem_req(mem_addr_t addr, mem_data_t dat,
                                            mem_sel_t sel, logic we);
    mem_req_t r;
    r.addr = addr;
    r.dat  = dat;
    r.sel  = sel;
    r.we   = we;
    return r;
  endfunction

  task automatic mem_access(input logic use_core, input mem_req_t req, input logic solo,
                            output mem_data_t rdata);
    int   n;
    logic own_ack;
    n     = 0;
    rdata = '0;
    @(posedge clk_main_a0);
    if (use_core) begin
      core_cyc_i <= 1'b1;
      core_stb_i <= 1'b1;
      core_req_i <= req;
    end else begin
      dma_cyc_i <= 1'b1;
      dma_stb_i <= 1'b1;
      dma_req_i <= req;
    end
    do begin
      @(posedge clk_main_a0);
      n++;
      own_ack = use_core ? core_ack_o : dma_ack_o;
      if (solo && (use_core ? dma_ack_o : core_ack_o)) begin
        $display("Memory ack reached the idle master at time %0t", $time);
        err_count++;
      end
    end while (!own_ack && n < ACK_LIMIT);
    if (!own_ack) begin
      $display("Memory master %s got no ack for address %h", use_core ? "core" : "dma",
               req.addr);
      err_count++;
    end
    rdata = use_core ? core_dat_o : dma_dat_o;
    if (use_core) begin
      core_cyc_i <= 1'b0;
      core_stb_i <= 1'b0;
    end else begin
      dma_cyc_i <= 1'b0;
      dma_stb_i <= 1'b0;
    end
  endtask

  task automatic expect_logged(input mem_req_t exp);
    if (req_log.size() == 0) begin
      $display("No request reached the memory port for address %h", exp.addr);
      err_count++;
    end else begin
      check_mem_req("mem_req_o", exp, req_log.pop_front());
    end
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_reset();
    @(posedge clk_main_a0);
    repeat (3) begin
      @(posedge clk_main_a0);
      check_status("vled_o", '0, vled_o);
      check_bit("ctrl_ack_o", 1'b0, ctrl_ack_o);
      check_bit("dma_ack_o", 1'b0, dma_ack_o);
      check_bit("core_ack_o", 1'b0, core_ack_o);
      check_bit("mem_cyc_o", 1'b0, mem_cyc_o);
      check_bit("mem_stb_o", 1'b0, mem_stb_o);
    end
    rst_main_n_sync <= 1'b1;
    repeat (2) @(posedge clk_main_a0);
    check_status("vled_o", '0, vled_o);
    @(posedge clk_main_a0);
    check_status("vled_o", `SHELL_VLED_PATTERN, vled_o);
  endtask

  task automatic test_fixed_regs();
    ctrl_data_t rd;
    ctrl_access(`SHELL_ADDR_ID0, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o ID0", `SHELL_ID0, rd);
    ctrl_access(`SHELL_ADDR_ID1, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o ID1", `SHELL_ID1, rd);
    ctrl_access(`SHELL_ADDR_STATUS0, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o STATUS0", '0, rd);
    ctrl_access(`SHELL_ADDR_STATUS1, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o STATUS1", '0, rd);
    ctrl_access(8'h40, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o unmapped", '0, rd);
    ctrl_access(`SHELL_ADDR_VLED, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o VLED", {16'h0, `SHELL_VLED_PATTERN}, rd);
  endtask

  task automatic test_dip();
    ctrl_data_t rd;
    @(posedge clk_main_a0);
    vdip_i <= 16'h5A3C;
    repeat (4) @(posedge clk_main_a0);
    ctrl_access(`SHELL_ADDR_VDIP, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o VDIP", 32'h0000_5A3C, rd);
    @(posedge clk_main_a0);
    vdip_i <= 16'hA5C3;
    repeat (4) @(posedge clk_main_a0);
    ctrl_access(`SHELL_ADDR_VDIP, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o VDIP", 32'h0000_A5C3, rd);
  endtask

  task automatic test_scratch();
    ctrl_data_t rd;
    ctrl_access(`SHELL_ADDR_SCRATCH, 32'h1122_3344, 4'hF, 1'b1, rd);
    ctrl_access(`SHELL_ADDR_SCRATCH, 32'hAABB_CCDD, 4'b0101, 1'b1, rd);
    ctrl_access(`SHELL_ADDR_SCRATCH, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o SCRATCH", 32'h11BB_33DD, rd);
    // ID words are read only
    ctrl_access(`SHELL_ADDR_ID0, 32'hFFFF_FFFF, 4'hF, 1'b1, rd);
    ctrl_access(`SHELL_ADDR_ID0, '0, 4'hF, 1'b0, rd);
    check_ctrl_data("ctrl_dat_o ID0", `SHELL_ID0, rd);
  endtask

  task automatic test_mem_single();
    mem_req_t  req;
    mem_data_t rd;
    mem_data_t fill;
    req = make_mem_req(32'h0000_0100, 32'hDEAD_0001, 4'hF, 1'b1);
    mem_access(1'b0, req, 1'b1, rd);
    expect_logged(req);
    req = make_mem_req(32'h0000_0100, '0, 4'hF, 1'b0);
    mem_access(1'b0, req, 1'b1, rd);
    expect_logged(req);
    check_mem_data("dma_dat_o", 32'hDEAD_0001, rd);
    // Half-word write merges into the fill pattern
    fill = fill_word(32'h0000_0200);
    req  = make_mem_req(32'h0000_0200, 32'h1234_5678, 4'b0011, 1'b1);
    mem_access(1'b1, req, 1'b1, rd);
    expect_logged(req);
    req = make_mem_req(32'h0000_0200, '0, 4'hF, 1'b0);
    mem_access(1'b1, req, 1'b1, rd);
    expect_logged(req);
    check_mem_data("core_dat_o", {fill[31:16], 16'h5678}, rd);
    req = make_mem_req(32'h0000_0300, '0, 4'hF, 1'b0);
    mem_access(1'b1, req, 1'b1, rd);
    expect_logged(req);
    check_mem_data("core_dat_o", fill_word(32'h0000_0300), rd);
  endtask

  task automatic test_mem_simultaneous();
    mem_addr_t dma_addr [3];
    mem_addr_t core_addr [3];
    mem_data_t dma_rd;
    mem_data_t core_rd;
    dma_addr  = '{32'h0000_1000, 32'h0000_1004, 32'h0000_1008};
    core_addr = '{32'h0000_2000, 32'h0000_2004, 32'h0000_2008};
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          mem_access(1'b0, make_mem_req(dma_addr[i], '0, 4'hF, 1'b0), 1'b0, dma_rd);
          check_mem_data("dma_dat_o", fill_word(dma_addr[i]), dma_rd);
        end
      end
      begin
        for (int i = 0; i < 3; i++) begin
          mem_access(1'b1, make_mem_req(core_addr[i], '0, 4'hF, 1'b0), 1'b0, core_rd);
          check_mem_data("core_dat_o", fill_word(core_addr[i]), core_rd);
        end
      end
    join
    // DMA wins the first tie and the masters then take turns
    for (int i = 0; i < 6; i++) begin
      expect_logged(make_mem_req((i % 2 == 0) ? dma_addr[i/2] : core_addr[i/2],
                                 '0, 4'hF, 1'b0));
    end
    // After a DMA win the next tie goes to the core
    mem_access(1'b0, make_mem_req(dma_addr[0], '0, 4'hF, 1'b0), 1'b1, dma_rd);
    check_mem_data("dma_dat_o", fill_word(dma_addr[0]), dma_rd);
    fork
      mem_access(1'b0, make_mem_req(dma_addr[1], '0, 4'hF, 1'b0), 1'b0, dma_rd);
      mem_access(1'b1, make_mem_req(core_addr[1], '0, 4'hF, 1'b0), 1'b0, core_rd);
    join
    check_mem_data("dma_dat_o", fill_word(dma_addr[1]), dma_rd);
    check_mem_data("core_dat_o", fill_word(core_addr[1]), core_rd);
    expect_logged(make_mem_req(dma_addr[0], '0, 4'hF, 1'b0));
    expect_logged(make_mem_req(core_addr[1], '0, 4'hF, 1'b0));
    expect_logged(make_mem_req(dma_addr[1], '0, 4'hF, 1'b0));
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    err_count       = 0;
    cycle_count     = 0;
    mem_busy        = 1'b0;
    wait_left       = 0;
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    ctrl_cyc_i      = 1'b0;
    ctrl_stb_i      = 1'b0;
    ctrl_req_i      = '0;
    dma_cyc_i       = 1'b0;
    dma_stb_i       = 1'b0;
    dma_req_i       = '0;
    core_cyc_i      = 1'b0;
    core_stb_i      = 1'b0;
    core_req_i      = '0;
    mem_ack_i       = 1'b0;
    mem_dat_i       = '0;
    vdip_i          = '0;

    test_reset();
    test_fixed_regs();
    test_dip();
    test_scratch();
    test_mem_single();
    test_mem_simultaneous();

    repeat (2) @(posedge clk_main_a0);
    $display("Finished with %0d errors", err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/shell_pkg.sv
src/status_leds.sv
src/wb_reg_slice.sv
src/ctrl_regs.sv
src/mem_arbiter.sv
src/shell_top.sv
bench/shell_properties.sv
bench/tb_shell_top.sv
